//--- zet_micro.f
+incdir+.
zet_micro_pkg.sv
zet_micro_rom.sv
zet_micro_data.sv
zet_micro_seq.sv
zet_micro_top.sv
tb_zet_micro.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass message.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f zet_micro.f \
  --top-module tb_zet_micro \
  -o tb_zet_micro > build.log 2>&1 \
  && ./obj_dir/tb_zet_micro > "$LOG" 2>&1 \
  || { cat build.log "$LOG" 2>/dev/null; echo "Build or run failed"; exit 1; }

cat "$LOG"

grep -qx "NO ERRORS" "$LOG" \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }

//--- tb_zet_micro.sv
// Self-checking testbench for the microcode subsystem; built and run by run_sim.sh.
`timescale 1ns/100ps
`default_nettype none

`include "zet_micro_consts.svh"

module tb_zet_micro import zet_micro_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_INSTR    = 60;
  localparam int MAX_WORDS    = 3;
  localparam int STALL_BOUND  = 8;
  // Longest sequence at the worst stall, per instruction.
  localparam int WATCH_CYCLES = NUM_INSTR * MAX_WORDS * STALL_BOUND + RESET_CYCLES + 16;

  logic       clk_i;
  logic       reset_i;
  dec_instr_t in_i;
  logic       in_valid_i;
  logic       in_ready_o;
  micro_op_t  out_o;
  logic       out_valid_o;
  logic       out_ready_i;

  // Scoreboard.
  micro_op_t   exp_q[$];
  micro_op_t   exp_word;
  micro_op_t   held_op;
  logic        hold_pending   = 1'b0;
  logic        accept_pending = 1'b0;
  logic        idle_pending   = 1'b0;
  int          error_count    = 0;
  int          check_count    = 0;
  int          accepted       = 0;
  int          words_expected = 0;
  int          words_seen     = 0;
  int          stall_run      = 0;
  int unsigned seed_val;

  zet_micro_top dut0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_i        (in_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_o       (out_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

  // ========================================
  // Reference sequence table
  // ========================================
  function automatic int seq_length(input logic [`MICRO_ADDR_WIDTH-1:0] entry);
    case (entry)
      `ENTRY_MOV_RR: return 1;
      `ENTRY_ADD_RI: return 2;
      `ENTRY_PUSH:   return 3;
      `ENTRY_LOAD:   return 2;
      `ENTRY_INC:    return 1;
      default:       return 2;
    endcase
  endfunction

  function automatic logic [`MICRO_ADDR_WIDTH-1:0] entry_of(input int k);
    case (k)
      0:       return `ENTRY_MOV_RR;
      1:       return `ENTRY_ADD_RI;
      2:       return `ENTRY_PUSH;
      3:       return `ENTRY_LOAD;
      4:       return `ENTRY_INC;
      default: return `ENTRY_STORE_IMM;
    endcase
  endfunction

  // Expected micro-op for word idx of the sequence that d starts.
  function automatic micro_op_t expected_op(input dec_instr_t d, input int idx);
    micro_op_t e;
    e      = '0;
    e.last = (idx == seq_length(d.entry) - 1);
    case (d.entry)
      `ENTRY_MOV_RR: begin
        e.ir.alu_op = ALU_MOV;
        e.ir.ctrl   = `CTRL_REG_WE | `CTRL_WORD;
        e.ir.addr_a = d.src;
        e.ir.addr_d = d.dst;
      end
      `ENTRY_ADD_RI: begin
        // Second word is a bare NOP.
        if (idx == 0) begin
          e.ir.alu_op = ALU_ADD;
          e.ir.ctrl   = `CTRL_REG_WE | `CTRL_FLAG_WE | `CTRL_WORD;
          e.ir.addr_a = d.dst;
          e.ir.addr_d = d.dst;
          e.imm       = d.imm;
        end
      end
      `ENTRY_PUSH: begin
        if (idx == 0) begin
          e.ir.alu_op = ALU_SUB;
          e.ir.ctrl   = `CTRL_REG_WE | `CTRL_WORD;
          e.ir.addr_a = `REG_SP;
          e.ir.addr_d = `REG_SP;
          e.imm       = 16'h0002;
        end else if (idx == 1) begin
          e.ir.alu_op = ALU_MOV;
          e.ir.ctrl   = `CTRL_MEM_WR | `CTRL_WORD;
          e.ir.addr_a = `REG_SP;
          e.ir.addr_b = d.src;
          e.ir.addr_s = `SEG_SS;
        end
      end
      `ENTRY_LOAD: begin
        if (idx == 0) begin
          e.ir.alu_op = ALU_ADDR;
          e.ir.ctrl   = `CTRL_MEM_RD | `CTRL_WORD;
          e.ir.addr_a = d.base;
          e.ir.addr_b = d.index;
          e.ir.addr_s = d.seg;
          e.off       = d.off;
        end else begin
          e.ir.alu_op = ALU_MOV;
          e.ir.ctrl   = `CTRL_REG_WE | `CTRL_WORD;
          e.ir.addr_d = d.dst;
        end
      end
      `ENTRY_INC: begin
        e.ir.alu_op = ALU_INC;
        e.ir.ctrl   = `CTRL_REG_WE | `CTRL_FLAG_WE | `CTRL_WORD;
        e.ir.addr_c = d.dst;
        e.ir.addr_d = d.dst;
        e.imm       = 16'h0001;
      end
      `ENTRY_STORE_IMM: begin
        // Both words use the instruction's segment.
        e.ir.alu_op = (idx == 0) ? ALU_ADDR : ALU_MOV;
        e.ir.addr_s = d.seg;
        if (idx == 0) begin
          e.ir.ctrl   = `CTRL_WORD;
          e.ir.addr_a = d.base;
          e.off       = d.off;
        end else begin
          e.ir.ctrl = `CTRL_MEM_WR | `CTRL_WORD;
          e.imm     = d.imm;
        end
      end
      default: ;
    endcase
    return e;
  endfunction

  // First six cover every entry once; then random.
  function automatic dec_instr_t random_instr(input int n);
    dec_instr_t d;
    d.entry = entry_of((n < 6) ? n : int'($urandom % 6));
    d.src   = 4'($urandom);
    d.dst   = 4'($urandom);
    d.base  = 4'($urandom);
    d.index = 4'($urandom);
    d.seg   = 2'($urandom);
    d.off   = 16'($urandom);
    d.imm   = 16'($urandom);
    return d;
  endfunction

  task automatic push_expected(input dec_instr_t d);
    for (int i = 0; i < seq_length(d.entry); i++) begin
      exp_q.push_back(expected_op(d, i));
      words_expected++;
    end
  endtask

  task automatic report_error(input string msg);
    error_count++;
    $display("ERROR at %0d ns: %s", $time, msg);
  endtask

  // ========================================
  // Clock, stalls and watchdog
  // ========================================
  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Random out_ready_i, never low for STALL_BOUND cycles in a row.
  initial begin
    logic ready;
    out_ready_i <= 1'b0;
    forever begin
      @(posedge clk_i);
      if (stall_run >= STALL_BOUND - 1) ready = 1'b1;
      else ready = (($urandom % 3) != 0);
      stall_run = ready ? 0 : stall_run + 1;
      out_ready_i <= ready;
    end
  end

  initial begin
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCH_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  // ========================================
  // Output monitor
  // ========================================
  always @(negedge clk_i) begin
    if (!reset_i) begin
      // Entry word one cycle after the input transfer.
      if (accept_pending) begin
        check_count++;
        assert (out_valid_o && !in_ready_o)
          else report_error("first word not valid the cycle after input transfer");
      end
      if (idle_pending) begin
        check_count++;
        assert (in_ready_o && !out_valid_o)
          else report_error("in_ready_o not high the cycle after the last word");
      end
      if (hold_pending) begin
        check_count++;
        assert (out_valid_o && out_o == held_op)
          else report_error($sformatf("stalled word changed, got %h held %h", out_o, held_op));
      end
      if (out_valid_o) begin
        check_count++;
        assert (!in_ready_o) else report_error("in_ready_o high during a sequence");
      end
      accept_pending = in_valid_i && in_ready_o;
      idle_pending   = 1'b0;
      hold_pending   = 1'b0;
      if (out_valid_o && out_ready_i) begin
        words_seen++;
        check_count++;
        assert (exp_q.size() != 0) else report_error("output word with no instruction behind it");
        if (exp_q.size() != 0) begin
          exp_word = exp_q.pop_front();
          assert (out_o == exp_word)
            else report_error($sformatf("word %0d mismatch, got %h expected %h",
                                        words_seen, out_o, exp_word));
          idle_pending = out_o.last;
        end
      end else if (out_valid_o) begin
        hold_pending = 1'b1;
        held_op      = out_o;
      end
    end
  end

  // ========================================
  // Stimulus
  // ========================================
  initial begin
    dec_instr_t instr;
    int         gap;
    int         n;
    seed_val = $urandom(32'h59d1e7e3);
    reset_i    <= 1'b1;
    in_valid_i <= 1'b0;
    in_i       <= '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;

    // Idle handshake before any input.
    repeat (2) begin
      @(negedge clk_i);
      check_count++;
      assert (in_ready_o && !out_valid_o) else report_error("wrong handshake after reset");
    end

    for (n = 0; n < NUM_INSTR; n++) begin
      instr = random_instr(n);
      @(posedge clk_i);
      in_i       <= instr;
      in_valid_i <= 1'b1;
      @(negedge clk_i);
      while (!in_ready_o) @(negedge clk_i);
      push_expected(instr);
      accepted++;
      // Gap of zero offers the next one mid-sequence.
      gap = int'($urandom % 3);
      if (gap != 0) begin
        @(posedge clk_i);
        in_valid_i <= 1'b0;
        repeat (gap - 1) @(posedge clk_i);
      end
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;

    // Drain the last sequence.
    @(negedge clk_i);
    while (exp_q.size() != 0 || !in_ready_o) @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    check_count++;
    assert (words_seen == words_expected)
      else report_error("word count does not match");

    $display("Summary: %0d instructions, %0d words, %0d checks, %0d errors",
             accepted, words_seen, check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- zet_micro_top.sv
// Microcode subsystem top; joins the sequencer and expander between the two valid/ready channels.
`timescale 1ns/100ps
`default_nettype none

`include "zet_micro_consts.svh"

module zet_micro_top import zet_micro_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  reset_i,
  input  wire dec_instr_t in_i,
  input  wire logic  in_valid_i,
  output logic       in_ready_o,
  output micro_op_t  out_o,
  output logic       out_valid_o,
  input  wire logic  out_ready_i
);

  // Sequencer to expander.
  logic [`MICRO_ADDR_WIDTH-1:0] n_micro;
  logic [3:0]  src, dst, base, index;
  logic [1:0]  seg;
  logic [15:0] off_q, imm_q;

  // Expander results.
  logic        end_seq;
  ir_t         ir;
  logic [15:0] off, imm;

  zet_micro_seq seq0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_i        (in_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .end_seq_i   (end_seq),
    .n_micro_o   (n_micro),
    .src_o       (src),
    .dst_o       (dst),
    .base_o      (base),
    .index_o     (index),
    .seg_o       (seg),
    .off_o       (off_q),
    .imm_o       (imm_q)
  );

  zet_micro_data data0 (
    .n_micro_i (n_micro),
    .off_i     (off_q),
    .imm_i     (imm_q),
    .src_i     (src),
    .dst_i     (dst),
    .base_i    (base),
    .index_i   (index),
    .seg_i     (seg),
    .end_seq_o (end_seq),
    .ir_o      (ir),
    .off_o     (off),
    .imm_o     (imm)
  );

  // Last follows the word's end flag.
  assign out_o = '{ir: ir, off: off, imm: imm, last: end_seq};

endmodule

`default_nettype wire

//--- zet_micro_seq.sv
// Micro sequencer; accepts a decoded instruction and steps the micro PC once per output transfer.
`timescale 1ns/100ps
`default_nettype none

`include "zet_micro_consts.svh"

module zet_micro_seq import zet_micro_pkg::*; (
  input  wire logic                         clk_i,
  input  wire logic                         reset_i,

  // Decoded instruction channel.
  input  wire dec_instr_t                   in_i,
  input  wire logic                         in_valid_i,
  output logic                              in_ready_o,

  // Micro-op channel handshake.
  output logic                              out_valid_o,
  input  wire logic                         out_ready_i,

  // From the expander.
  input  wire logic                         end_seq_i,

  // To the expander.
  output logic [`MICRO_ADDR_WIDTH-1:0]      n_micro_o,
  output logic [3:0]                        src_o,
  output logic [3:0]                        dst_o,
  output logic [3:0]                        base_o,
  output logic [3:0]                        index_o,
  output logic [1:0]                        seg_o,
  output logic [15:0]                       off_o,
  output logic [15:0]                       imm_o
);

  seq_state_e                     state_q;
  logic [`MICRO_ADDR_WIDTH-1:0]   upc_q;
  dec_instr_t                     instr_q;
  logic                           in_fire;
  logic                           out_fire;

  // ========================================
  // Handshakes
  // ========================================
  // Ready only between sequences.
  assign in_ready_o  = (state_q == ST_IDLE);
  // Valid for the whole sequence.
  assign out_valid_o = (state_q == ST_RUN);

  assign in_fire  = in_valid_i & in_ready_o;
  assign out_fire = out_valid_o & out_ready_i;

  // ========================================
  // State and micro PC
  // ========================================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      upc_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          // Jump to the entry word.
          if (in_fire) begin
            state_q <= ST_RUN;
            upc_q   <= in_i.entry;
          end
        end
        ST_RUN: begin
          if (out_fire) begin
            // Last word gone, wait for the next instruction.
            if (end_seq_i) begin
              state_q <= ST_IDLE;
            end else begin
              upc_q <= upc_q + 1'b1;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Instruction fields, held for the whole sequence.
  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      instr_q <= in_i;
    end
  end

  // ========================================
  // Outputs to the expander
  // ========================================
  assign n_micro_o = upc_q;
  assign src_o     = instr_q.src;
  assign dst_o     = instr_q.dst;
  assign base_o    = instr_q.base;
  assign index_o   = instr_q.index;
  assign seg_o     = instr_q.seg;
  assign off_o     = instr_q.off;
  assign imm_o     = instr_q.imm;

endmodule

`default_nettype wire

//--- zet_micro_data.sv
// Micro-word expander; reads the ROM and substitutes decoded fields into the internal instruction.
`timescale 1ns/100ps
`default_nettype none

`include "zet_micro_consts.svh"

module zet_micro_data import zet_micro_pkg::*; (
  input  wire logic [`MICRO_ADDR_WIDTH-1:0] n_micro_i,
  input  wire logic [15:0]                  off_i,
  input  wire logic [15:0]                  imm_i,
  input  wire logic [3:0]                   src_i,
  input  wire logic [3:0]                   dst_i,
  input  wire logic [3:0]                   base_i,
  input  wire logic [3:0]                   index_i,
  input  wire logic [1:0]                   seg_i,
  output logic                              end_seq_o,
  output ir_t                               ir_o,
  output logic [15:0]                       off_o,
  output logic [15:0]                       imm_o
);

  micro_word_t micro;

  zet_micro_rom rom0 (
    .n_micro_i (n_micro_i),
    .micro_o   (micro)
  );

  assign end_seq_o = micro.end_seq;

  // ========================================
  // Field substitution
  // ========================================
  always_comb begin
    ir_o.alu_op = micro.alu_op;
    ir_o.ctrl   = micro.ctrl;

    // Field a.
    case (micro.var_a)
      SEL_A_LIT:  ir_o.addr_a = micro.micro_a;
      SEL_A_BASE: ir_o.addr_a = base_i;
      SEL_A_DST:  ir_o.addr_a = dst_i;
      default:    ir_o.addr_a = src_i;
    endcase

    // Field b, src for both upper codes.
    case (micro.var_b)
      SEL_B_LIT:   ir_o.addr_b = micro.micro_b;
      SEL_B_INDEX: ir_o.addr_b = index_i;
      default:     ir_o.addr_b = src_i;
    endcase

    case (micro.var_c)
      SEL_CD_LIT: ir_o.addr_c = micro.micro_c;
      SEL_CD_DST: ir_o.addr_c = dst_i;
      default:    ir_o.addr_c = src_i;
    endcase

    case (micro.var_d)
      SEL_CD_LIT: ir_o.addr_d = micro.micro_d;
      SEL_CD_DST: ir_o.addr_d = dst_i;
      default:    ir_o.addr_d = src_i;
    endcase

    // Segment from the word or the instruction.
    ir_o.addr_s = micro.var_s ? seg_i : micro.micro_s;
  end

  // Immediate constants and pass-throughs.
  always_comb begin
    case (micro.var_imm)
      IMM_ZERO:  imm_o = 16'h0000;
      IMM_TWO:   imm_o = 16'h0002;
      IMM_FOUR:  imm_o = 16'h0004;
      IMM_OFF:   imm_o = off_i;
      IMM_IMM:   imm_o = imm_i;
      IMM_FFFF:  imm_o = 16'hffff;
      IMM_THREE: imm_o = 16'h0003;
      default:   imm_o = 16'h0001;
    endcase
  end

  // Displacement only when the word asks for it.
  assign off_o = micro.var_off ? off_i : 16'h0000;

endmodule

`default_nettype wire

//--- zet_micro_rom.sv
// Combinational micro-ROM with the fixed linear sequences; read by the micro-word expander.
`timescale 1ns/100ps
`default_nettype none

`include "zet_micro_consts.svh"

module zet_micro_rom import zet_micro_pkg::*; (
  input  wire logic [`MICRO_ADDR_WIDTH-1:0] n_micro_i,
  output micro_word_t                       micro_o
);

  micro_word_t word;

  // ========================================
  // Sequence table
  // ========================================
  always_comb begin
    // Unused addresses read as NOP with end set.
    word         = '0;
    word.end_seq = 1'b1;

    case (n_micro_i)
      // MOV reg, reg.
      `ENTRY_MOV_RR: begin
        word.alu_op = ALU_MOV;
        word.ctrl   = `CTRL_REG_WE | `CTRL_WORD;
        word.var_a  = SEL_A_SRC;
        word.var_d  = SEL_CD_DST;
      end

      // ADD reg, imm.
      `ENTRY_ADD_RI: begin
        word.end_seq = 1'b0;
        word.alu_op  = ALU_ADD;
        word.ctrl    = `CTRL_REG_WE | `CTRL_FLAG_WE | `CTRL_WORD;
        word.var_a   = SEL_A_DST;
        word.var_d   = SEL_CD_DST;
        word.var_imm = IMM_IMM;
      end
      // Closing NOP.
      `ENTRY_ADD_RI + 5'd1: word.end_seq = 1'b1;

      // PUSH reg. Drop SP by two first.
      `ENTRY_PUSH: begin
        word.end_seq = 1'b0;
        word.alu_op  = ALU_SUB;
        word.ctrl    = `CTRL_REG_WE | `CTRL_WORD;
        word.micro_a = `REG_SP;
        word.micro_d = `REG_SP;
        word.var_imm = IMM_TWO;
      end
      // Store src at SS:SP.
      `ENTRY_PUSH + 5'd1: begin
        word.end_seq = 1'b0;
        word.alu_op  = ALU_MOV;
        word.ctrl    = `CTRL_MEM_WR | `CTRL_WORD;
        word.micro_a = `REG_SP;
        word.var_b   = SEL_B_SRC;
        word.micro_s = `SEG_SS;
      end
      `ENTRY_PUSH + 5'd2: word.end_seq = 1'b1;

      // LOAD reg, [base+index+disp].
      `ENTRY_LOAD: begin
        word.end_seq = 1'b0;
        word.alu_op  = ALU_ADDR;
        word.ctrl    = `CTRL_MEM_RD | `CTRL_WORD;
        word.var_a   = SEL_A_BASE;
        word.var_b   = SEL_B_INDEX;
        word.var_off = 1'b1;
        word.var_s   = 1'b1;
      end
      // Write the loaded data back.
      `ENTRY_LOAD + 5'd1: begin
        word.alu_op = ALU_MOV;
        word.ctrl   = `CTRL_REG_WE | `CTRL_WORD;
        word.var_d  = SEL_CD_DST;
      end

      // INC reg.
      `ENTRY_INC: begin
        word.alu_op  = ALU_INC;
        word.ctrl    = `CTRL_REG_WE | `CTRL_FLAG_WE | `CTRL_WORD;
        word.var_c   = SEL_CD_DST;
        word.var_d   = SEL_CD_DST;
        word.var_imm = IMM_ONE;
      end

      // STORE [base+disp], imm.
      `ENTRY_STORE_IMM: begin
        word.end_seq = 1'b0;
        word.alu_op  = ALU_ADDR;
        word.ctrl    = `CTRL_WORD;
        word.var_a   = SEL_A_BASE;
        word.var_off = 1'b1;
        word.var_s   = 1'b1;
      end
      `ENTRY_STORE_IMM + 5'd1: begin
        word.alu_op  = ALU_MOV;
        word.ctrl    = `CTRL_MEM_WR | `CTRL_WORD;
        word.var_s   = 1'b1;
        word.var_imm = IMM_IMM;
      end

      default: ;
    endcase
  end

  assign micro_o = word;

endmodule

`default_nettype wire

//--- zet_micro_pkg.sv
// Types shared by the micro sequencer, expander, ROM and testbench; import with zet_micro_pkg::*.
`default_nettype none

`include "zet_micro_consts.svh"

package zet_micro_pkg;

  // ALU function, top nibble of high_ir.
  typedef enum logic [3:0] {
    ALU_NOP  = 4'd0,
    ALU_ADD  = 4'd1,
    ALU_SUB  = 4'd2,
    ALU_INC  = 4'd3,
    ALU_MOV  = 4'd4,
    ALU_ADDR = 4'd5
  } alu_op_e;

  // Field a source.
  typedef enum logic [1:0] {SEL_A_LIT, SEL_A_BASE, SEL_A_DST, SEL_A_SRC} sel_a_e;
  // Field b source; code 3 also picks src.
  typedef enum logic [1:0] {SEL_B_LIT, SEL_B_INDEX, SEL_B_SRC} sel_b_e;
  // Fields c and d share one selector set.
  typedef enum logic [1:0] {SEL_CD_LIT, SEL_CD_DST, SEL_CD_SRC} sel_cd_e;

  // Immediate source, order fixed by the ROM encoding.
  typedef enum logic [2:0] {
    IMM_ZERO, IMM_TWO, IMM_FOUR, IMM_OFF, IMM_IMM, IMM_FFFF, IMM_THREE, IMM_ONE
  } imm_sel_e;

  typedef enum logic {ST_IDLE, ST_RUN} seq_state_e;

  // Decoded instruction from the front end.
  typedef struct packed {
    logic [`MICRO_ADDR_WIDTH-1:0] entry;
    logic [3:0]  src;
    logic [3:0]  dst;
    logic [3:0]  base;
    logic [3:0]  index;
    logic [1:0]  seg;
    logic [15:0] off;
    logic [15:0] imm;
  } dec_instr_t;

  // Internal instruction word, MSB first.
  typedef struct packed {
    alu_op_e     alu_op;
    logic [13:0] ctrl;
    logic [3:0]  addr_d;
    logic [3:0]  addr_c;
    logic [3:0]  addr_b;
    logic [3:0]  addr_a;
    logic [1:0]  addr_s;
  } ir_t;

  // One ROM word; alu_op and ctrl together form high_ir.
  typedef struct packed {
    logic        end_seq;
    imm_sel_e    var_imm;
    logic        var_off;
    sel_cd_e     var_d;
    sel_cd_e     var_c;
    sel_b_e      var_b;
    sel_a_e      var_a;
    logic        var_s;
    alu_op_e     alu_op;
    logic [13:0] ctrl;
    logic [3:0]  micro_d;
    logic [3:0]  micro_c;
    logic [3:0]  micro_b;
    logic [3:0]  micro_a;
    logic [1:0]  micro_s;
  } micro_word_t;

  // Micro-op leaving the subsystem.
  typedef struct packed {
    ir_t         ir;
    logic [15:0] off;
    logic [15:0] imm;
    logic        last;
  } micro_op_t;

endpackage

`default_nettype wire

//--- zet_micro_consts.svh
// Shared widths, control masks and micro-ROM entry points; include where a constant is needed.
`ifndef ZET_MICRO_CONSTS_SVH
`define ZET_MICRO_CONSTS_SVH

// ========================================
// Widths
// ========================================
// Micro address, 32 words of ROM.
`define MICRO_ADDR_WIDTH 5
// One ROM word.
`define MICRO_DATA_WIDTH 50
// Internal instruction word.
`define IR_SIZE          36

// ========================================
// Control field masks (14 bits)
// ========================================
`define CTRL_REG_WE      14'h0001
`define CTRL_FLAG_WE     14'h0002
`define CTRL_MEM_RD      14'h0004
`define CTRL_MEM_WR      14'h0008
`define CTRL_WORD        14'h0010

// Fixed register and segment literals.
`define REG_SP           4'd4
`define SEG_SS           2'd2

// Sequence entry points in the micro-ROM.
`define ENTRY_MOV_RR     5'd0
`define ENTRY_ADD_RI     5'd2
`define ENTRY_PUSH       5'd4
`define ENTRY_LOAD       5'd8
`define ENTRY_INC        5'd12
`define ENTRY_STORE_IMM  5'd16

`endif
